//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_gpio
FILELIST  ?= gpio.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/tb_clkgen.sv
// Clock and reset source for the GPIO testbench, instantiated by the testbench top
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int Period      = 100,
  parameter int ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- bench/tb_gpio.sv
// Top of the GPIO testbench that drives the register port and pins while assertions check the responses
`timescale 1ns/1ps

`include "gpio_params.svh"

module tb_gpio
  import gpio_reg_pkg::*;
  import gpio_pin_pkg::*;
();

  // Tests need well under 500 cycles
  localparam int MaxCycles = 2000;

  logic                clk;
  logic                rst_n;
  logic                reg_we;
  logic                reg_re;
  logic [`GPIO_AW-1:0] reg_addr;
  reg_word_t           reg_wdata;
  reg_word_t           reg_rdata;
  logic                reg_rvalid;
  pin_vec_t            gpio_in;
  pin_vec_t            gpio_out;
  pin_vec_t            gpio_oe;
  pin_vec_t            intr;

  // Model of the block
  pin_vec_t  exp_out, exp_oe, exp_state, exp_ien, exp_hi, exp_lo;
  reg_word_t exp_rdata;
  logic      intr_chk;
  logic [15:0] lfsr;
  int        errors, cycles, test_no, tests_failed, err_mark;

  tb_clkgen #(.Period(100), .ResetCycles(8)) u_clkgen (.clk_o(clk), .rst_no(rst_n));

  gpio UUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .reg_we_i    (reg_we),
    .reg_re_i    (reg_re),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .reg_rvalid_o(reg_rvalid),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_out),
    .gpio_oe_o   (gpio_oe),
    .intr_o      (intr)
  );

  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    reg_rvalid |-> reg_rdata == exp_rdata)
  else begin
    $display("Fail at %0t: reg_rdata_o = %h, expected %h",
             $time, $sampled(reg_rdata), $sampled(exp_rdata));
    errors++;
  end

  // Read response is a one-cycle pulse on the cycle after the strobe
  a_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    reg_rvalid == $past(reg_re))
  else begin
    $display("Fail at %0t: reg_rvalid_o = %b, expected %b", $time, $sampled(reg_rvalid),
             !$sampled(reg_rvalid));
    errors++;
  end

  a_out: assert property (@(posedge clk) disable iff (!rst_n) gpio_out == exp_out)
  else begin
    $display("Fail at %0t: gpio_o = %h, expected %h", $time, $sampled(gpio_out),
             $sampled(exp_out));
    errors++;
  end

  a_oe: assert property (@(posedge clk) disable iff (!rst_n) gpio_oe == exp_oe)
  else begin
    $display("Fail at %0t: gpio_oe_o = %h, expected %h", $time, $sampled(gpio_oe),
             $sampled(exp_oe));
    errors++;
  end

  a_intr: assert property (@(posedge clk) disable iff (!rst_n)
    intr_chk |-> intr == (exp_state & exp_ien))
  else begin
    $display("Fail at %0t: intr_o = %h, expected %h", $time, $sampled(intr),
             $sampled(exp_state & exp_ien));
    errors++;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output reg_word_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w[i] = lfsr[0];
    end
  endtask

  function automatic pin_vec_t merge_half(input pin_vec_t cur, input reg_word_t w,
                                          input logic upper);
    half_vec_t old;
    pin_vec_t  res;
    old = upper ? cur[31:16] : cur[15:0];
    res = cur;
    if (upper) begin
      res[31:16] = (old & ~w[31:16]) | (w[15:0] & w[31:16]);
    end else begin
      res[15:0] = (old & ~w[31:16]) | (w[15:0] & w[31:16]);
    end
    return res;
  endfunction

  function automatic pin_vec_t level_events(input pin_vec_t p);
    return (p & exp_hi) | (~p & exp_lo);
  endfunction

  task automatic settle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic reg_write(input logic [`GPIO_AW-1:0] addr, input reg_word_t data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    settle(1);
    reg_we = 1'b0;
    // Mirror the write now that it has taken effect
    case (addr)
      GPIO_DIRECT_OUT:       exp_out = data;
      GPIO_MASKED_OUT_LOWER: exp_out = merge_half(exp_out, data, 1'b0);
      GPIO_MASKED_OUT_UPPER: exp_out = merge_half(exp_out, data, 1'b1);
      GPIO_DIRECT_OE:        exp_oe = data;
      GPIO_MASKED_OE_LOWER:  exp_oe = merge_half(exp_oe, data, 1'b0);
      GPIO_MASKED_OE_UPPER:  exp_oe = merge_half(exp_oe, data, 1'b1);
      GPIO_INTR_STATE:       exp_state = (exp_state & ~data) | level_events(gpio_in);
      GPIO_INTR_ENABLE:      exp_ien = data;
      GPIO_INTR_TEST:        exp_state = exp_state | data;
      GPIO_CTRL_EN_LVLHIGH:  exp_hi = data;
      GPIO_CTRL_EN_LVLLOW:   exp_lo = data;
      default: ;
    endcase
  endtask

  task automatic reg_read(input logic [`GPIO_AW-1:0] addr, input reg_word_t expected);
    int waited;
    reg_re    = 1'b1;
    reg_addr  = addr;
    exp_rdata = expected;
    waited    = 0;
    settle(1);
    reg_re = 1'b0;
    while (!reg_rvalid && waited < 4) begin
      settle(1);
      waited++;
    end
    if (!reg_rvalid) begin
      $display("No read response for address %0d at %0t", addr, $time);
      errors++;
    end else begin
      // Data is compared by a_rdata on the next edge
      settle(1);
    end
  endtask

  task automatic check_intr();
    intr_chk = 1'b1;
    settle(2);
    intr_chk = 1'b0;
  endtask

  task automatic end_test(input string name);
    test_no++;
    if (errors == err_mark) begin
      $display("Test %0d %s: passed", test_no, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", test_no, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic masked_case(input logic [`GPIO_AW-1:0] base);
    reg_word_t w;
    pin_vec_t  cur;
    int        off;
    rand_word(w);
    reg_write(base, w);
    reg_read(base, w);
    for (int j = 0; j < 4; j++) begin
      off = 1 + j % 2;
      rand_word(w);
      reg_write(base + `GPIO_AW'(off), w);
      cur = (base == GPIO_DIRECT_OUT) ? exp_out : exp_oe;
      reg_read(base + `GPIO_AW'(off),
               {half_vec_t'(0), (off == 2) ? cur[31:16] : cur[15:0]});
    end
    reg_read(base, (base == GPIO_DIRECT_OUT) ? exp_out : exp_oe);
  endtask

  // Event kind 0 is rising, 1 falling, 2 high level and 3 low level
  task automatic event_case(input logic [`GPIO_AW-1:0] en_addr, input int kind);
    reg_word_t p0, p1, en, ien, c, ev;
    rand_word(p0);
    gpio_in = p0;
    settle(3);
    reg_write(GPIO_INTR_STATE, '1);
    rand_word(en);
    reg_write(en_addr, en);
    reg_read(en_addr, en);
    rand_word(p1);
    gpio_in = p1;
    settle(3);
    case (kind)
      0:       ev = ~p0 & p1;
      1:       ev = p0 & ~p1;
      2:       ev = p0 | p1;
      default: ev = ~p0 | ~p1;
    endcase
    exp_state = exp_state | (ev & en);
    reg_read(GPIO_INTR_STATE, exp_state);
    rand_word(ien);
    reg_write(GPIO_INTR_ENABLE, ien);
    reg_read(GPIO_INTR_ENABLE, ien);
    check_intr();
    rand_word(c);
    reg_write(GPIO_INTR_STATE, c);
    reg_read(GPIO_INTR_STATE, exp_state);
    check_intr();
    reg_write(en_addr, '0);
  endtask

  initial begin
    while (cycles < MaxCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the tests did not complete", MaxCycles);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    reg_word_t p, q;
    reg_we = 1'b0;
    reg_re = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    gpio_in = '0;
    {exp_out, exp_oe, exp_state, exp_ien, exp_hi, exp_lo} = '0;
    exp_rdata = '0;
    intr_chk = 1'b0;
    lfsr = 16'd6444;
    {errors, cycles, test_no, tests_failed, err_mark} = '0;
    wait (rst_n);
    settle(1);

    for (int a = 0; a < 16; a++) begin
      reg_read(`GPIO_AW'(a), '0);
    end
    check_intr();
    end_test("reset values");

    masked_case(GPIO_DIRECT_OUT);
    masked_case(GPIO_DIRECT_OE);
    end_test("direct and masked writes");

    for (int i = 0; i < 3; i++) begin
      rand_word(p);
      gpio_in = p;
      settle(1);
      reg_read(GPIO_DATA_IN, p);
    end
    end_test("unfiltered input");

    // Let the filter's stable level catch up before switching it in
    settle(20);
    reg_write(GPIO_CTRL_EN_INPUT_FILTER, '1);
    reg_read(GPIO_CTRL_EN_INPUT_FILTER, '1);
    p = gpio_in;
    rand_word(q);
    gpio_in = q;
    settle(8);
    reg_read(GPIO_DATA_IN, p);
    gpio_in = p;
    settle(20);
    reg_read(GPIO_DATA_IN, p);
    gpio_in = q;
    settle(20);
    reg_read(GPIO_DATA_IN, q);
    reg_write(GPIO_CTRL_EN_INPUT_FILTER, '0);
    end_test("input filter");

    event_case(GPIO_CTRL_EN_RISING, 0);
    event_case(GPIO_CTRL_EN_FALLING, 1);
    event_case(GPIO_CTRL_EN_LVLHIGH, 2);
    event_case(GPIO_CTRL_EN_LVLLOW, 3);
    end_test("interrupt events");

    reg_write(GPIO_INTR_STATE, '1);
    rand_word(p);
    reg_write(GPIO_INTR_TEST, p);
    reg_read(GPIO_INTR_STATE, exp_state);
    reg_read(GPIO_INTR_TEST, '0);
    check_intr();
    reg_write(GPIO_INTR_STATE, '1);
    reg_read(GPIO_INTR_STATE, '0);
    end_test("interrupt test register");

    $display("%0d tests run, %0d failed, %0d errors in total", test_no, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- common/gpio_params.svh
// Size and timing constants for the GPIO block, included by the packages and modules that need them

`ifndef GPIO_PARAMS_SVH
`define GPIO_PARAMS_SVH

// Pins on the block
`define GPIO_WIDTH 32

// Bits in one masked half
`define GPIO_HALF 16

// Stable cycles before the debounce filter passes a new level
`define GPIO_FILTER_CYCLES 16

// Register word address width
`define GPIO_AW 4

`endif

//--- common/gpio_pin_pkg.sv
// Pin-side vector types for the GPIO data path, imported by the pin and interrupt logic

`include "gpio_params.svh"

package gpio_pin_pkg;

  // One bit per pin
  typedef logic [`GPIO_WIDTH-1:0] pin_vec_t;

  // One masked half
  // In a masked write word the mask sits in the upper half, the data in the lower
  typedef logic [`GPIO_HALF-1:0] half_vec_t;

endpackage

//--- common/gpio_reg_pkg.sv
// Register map and register-bus word type shared by the GPIO register block and its users

`include "gpio_params.svh"

package gpio_reg_pkg;

  // Word addresses of the register port
  typedef enum logic [`GPIO_AW-1:0] {
    GPIO_DATA_IN              = 0,
    GPIO_DIRECT_OUT           = 1,
    GPIO_MASKED_OUT_LOWER     = 2,
    GPIO_MASKED_OUT_UPPER     = 3,
    GPIO_DIRECT_OE            = 4,
    GPIO_MASKED_OE_LOWER      = 5,
    GPIO_MASKED_OE_UPPER      = 6,
    GPIO_INTR_STATE           = 7,
    GPIO_INTR_ENABLE          = 8,
    GPIO_INTR_TEST            = 9,
    GPIO_CTRL_EN_RISING       = 10,
    GPIO_CTRL_EN_FALLING      = 11,
    GPIO_CTRL_EN_LVLHIGH      = 12,
    GPIO_CTRL_EN_LVLLOW       = 13,
    GPIO_CTRL_EN_INPUT_FILTER = 14
  } gpio_reg_e;

  // One register data word
  typedef logic [31:0] reg_word_t;

endpackage

//--- gpio.f
+incdir+common
common/gpio_reg_pkg.sv
common/gpio_pin_pkg.sv
source/gpio_filter_ctr.sv
source/gpio_masked_reg.sv
source/gpio_intr.sv
gpio_reg/gpio_reg_top.sv
source/gpio.sv
bench/tb_clkgen.sv
bench/tb_gpio.sv

//--- gpio_reg/gpio_reg_top.sv
// Address decode, configuration registers and read-back that the GPIO top level uses as its register port

`timescale 1ns/1ps

`include "gpio_params.svh"

module gpio_reg_top
  import gpio_reg_pkg::*;
  import gpio_pin_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               we_i,
  input  logic               re_i,
  input  logic [`GPIO_AW-1:0] addr_i,
  input  reg_word_t          wdata_i,
  output reg_word_t          rdata_o,
  output logic               rvalid_o,
  output logic               out_wr_o,
  output logic               out_lo_wr_o,
  output logic               out_hi_wr_o,
  output logic               oe_wr_o,
  output logic               oe_lo_wr_o,
  output logic               oe_hi_wr_o,
  output reg_word_t          wdata_o,
  output pin_vec_t           rise_en_o,
  output pin_vec_t           fall_en_o,
  output pin_vec_t           hi_en_o,
  output pin_vec_t           lo_en_o,
  output pin_vec_t           intr_en_o,
  output pin_vec_t           filt_en_o,
  output logic               intr_clr_o,
  output logic               intr_test_o,
  input  pin_vec_t           data_in_i,
  input  pin_vec_t           out_q_i,
  input  pin_vec_t           oe_q_i,
  input  pin_vec_t           intr_state_i
);

  gpio_reg_e addr;
  pin_vec_t  rise_en_q, fall_en_q, hi_en_q, lo_en_q, intr_en_q, filt_en_q;
  reg_word_t rdata_d, rdata_q;
  logic      rvalid_q;

  assign addr = gpio_reg_e'(addr_i);

  // Single-cycle pulses that act at the same edge as the write
  assign out_wr_o    = we_i && (addr == GPIO_DIRECT_OUT);
  assign out_lo_wr_o = we_i && (addr == GPIO_MASKED_OUT_LOWER);
  assign out_hi_wr_o = we_i && (addr == GPIO_MASKED_OUT_UPPER);
  assign oe_wr_o     = we_i && (addr == GPIO_DIRECT_OE);
  assign oe_lo_wr_o  = we_i && (addr == GPIO_MASKED_OE_LOWER);
  assign oe_hi_wr_o  = we_i && (addr == GPIO_MASKED_OE_UPPER);
  assign intr_clr_o  = we_i && (addr == GPIO_INTR_STATE);
  assign intr_test_o = we_i && (addr == GPIO_INTR_TEST);
  assign wdata_o     = wdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rise_en_q <= '0;
      fall_en_q <= '0;
      hi_en_q   <= '0;
      lo_en_q   <= '0;
      intr_en_q <= '0;
      filt_en_q <= '0;
    end else if (we_i) begin
      case (addr)
        GPIO_INTR_ENABLE:          intr_en_q <= wdata_i;
        GPIO_CTRL_EN_RISING:       rise_en_q <= wdata_i;
        GPIO_CTRL_EN_FALLING:      fall_en_q <= wdata_i;
        GPIO_CTRL_EN_LVLHIGH:      hi_en_q   <= wdata_i;
        GPIO_CTRL_EN_LVLLOW:       lo_en_q   <= wdata_i;
        GPIO_CTRL_EN_INPUT_FILTER: filt_en_q <= wdata_i;
        default: ;
      endcase
    end
  end

  // Masked registers read back the half with a zero mask
  always_comb begin
    case (addr)
      GPIO_DATA_IN:              rdata_d = data_in_i;
      GPIO_DIRECT_OUT:           rdata_d = out_q_i;
      GPIO_MASKED_OUT_LOWER:     rdata_d = {half_vec_t'(0), out_q_i[`GPIO_HALF-1:0]};
      GPIO_MASKED_OUT_UPPER:     rdata_d = {half_vec_t'(0), out_q_i[`GPIO_WIDTH-1:`GPIO_HALF]};
      GPIO_DIRECT_OE:            rdata_d = oe_q_i;
      GPIO_MASKED_OE_LOWER:      rdata_d = {half_vec_t'(0), oe_q_i[`GPIO_HALF-1:0]};
      GPIO_MASKED_OE_UPPER:      rdata_d = {half_vec_t'(0), oe_q_i[`GPIO_WIDTH-1:`GPIO_HALF]};
      GPIO_INTR_STATE:           rdata_d = intr_state_i;
      GPIO_INTR_ENABLE:          rdata_d = intr_en_q;
      GPIO_CTRL_EN_RISING:       rdata_d = rise_en_q;
      GPIO_CTRL_EN_FALLING:      rdata_d = fall_en_q;
      GPIO_CTRL_EN_LVLHIGH:      rdata_d = hi_en_q;
      GPIO_CTRL_EN_LVLLOW:       rdata_d = lo_en_q;
      GPIO_CTRL_EN_INPUT_FILTER: rdata_d = filt_en_q;
      default:                   rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q  <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= re_i;
      if (re_i) begin
        rdata_q <= rdata_d;
      end
    end
  end

  assign rdata_o   = rdata_q;
  assign rvalid_o  = rvalid_q;
  assign rise_en_o = rise_en_q;
  assign fall_en_o = fall_en_q;
  assign hi_en_o   = hi_en_q;
  assign lo_en_o   = lo_en_q;
  assign intr_en_o = intr_en_q;
  assign filt_en_o = filt_en_q;

  a_no_rw_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(we_i && re_i));

endmodule

//--- source/gpio.sv
// GPIO top level joining the register port, input filters, output registers and interrupts

`timescale 1ns/1ps

`include "gpio_params.svh"

module gpio
  import gpio_reg_pkg::*;
  import gpio_pin_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                reg_we_i,
  input  logic                reg_re_i,
  input  logic [`GPIO_AW-1:0] reg_addr_i,
  input  reg_word_t           reg_wdata_i,
  output reg_word_t           reg_rdata_o,
  output logic                reg_rvalid_o,
  input  pin_vec_t            gpio_i,
  output pin_vec_t            gpio_o,
  output pin_vec_t            gpio_oe_o,
  output pin_vec_t            intr_o
);

  logic      out_wr, out_lo_wr, out_hi_wr;
  logic      oe_wr, oe_lo_wr, oe_hi_wr;
  logic      intr_clr, intr_test;
  reg_word_t wdata;
  pin_vec_t  rise_en, fall_en, hi_en, lo_en, intr_en, filt_en;
  pin_vec_t  data_in;
  pin_vec_t  intr_state;

  gpio_reg_top u_reg (
    .clk_i, .rst_ni,
    .we_i        (reg_we_i),     .re_i        (reg_re_i),
    .addr_i      (reg_addr_i),   .wdata_i     (reg_wdata_i),
    .rdata_o     (reg_rdata_o),  .rvalid_o    (reg_rvalid_o),
    .out_wr_o    (out_wr),       .out_lo_wr_o (out_lo_wr),    .out_hi_wr_o (out_hi_wr),
    .oe_wr_o     (oe_wr),        .oe_lo_wr_o  (oe_lo_wr),     .oe_hi_wr_o  (oe_hi_wr),
    .wdata_o     (wdata),
    .rise_en_o   (rise_en),      .fall_en_o   (fall_en),
    .hi_en_o     (hi_en),        .lo_en_o     (lo_en),
    .intr_en_o   (intr_en),      .filt_en_o   (filt_en),
    .intr_clr_o  (intr_clr),     .intr_test_o (intr_test),
    .data_in_i   (data_in),      .out_q_i     (gpio_o),
    .oe_q_i      (gpio_oe_o),    .intr_state_i(intr_state)
  );

  // Optional debounce per pin
  for (genvar i = 0; i < `GPIO_WIDTH; i++) begin : gen_filter
    gpio_filter_ctr #(.Cycles(`GPIO_FILTER_CYCLES)) u_filter (
      .clk_i, .rst_ni,
      .enable_i (filt_en[i]),
      .in_i     (gpio_i[i]),
      .out_o    (data_in[i])
    );
  end

  gpio_masked_reg u_out (
    .clk_i, .rst_ni,
    .wr_i(out_wr), .lo_wr_i(out_lo_wr), .hi_wr_i(out_hi_wr),
    .wdata_i(wdata), .q_o(gpio_o)
  );

  gpio_masked_reg u_oe (
    .clk_i, .rst_ni,
    .wr_i(oe_wr), .lo_wr_i(oe_lo_wr), .hi_wr_i(oe_hi_wr),
    .wdata_i(wdata), .q_o(gpio_oe_o)
  );

  gpio_intr u_intr (
    .clk_i, .rst_ni,
    .data_i   (data_in),
    .rise_en_i(rise_en), .fall_en_i(fall_en), .hi_en_i(hi_en), .lo_en_i(lo_en),
    .intr_en_i(intr_en),
    .clr_i    (intr_clr), .test_i(intr_test), .wdata_i(wdata),
    .state_o  (intr_state), .intr_o(intr_o)
  );

endmodule

//--- source/gpio_filter_ctr.sv
// Debounce filter for one input pin, instantiated per pin by the GPIO top level

`timescale 1ns/1ps

`include "gpio_params.svh"

module gpio_filter_ctr #(
  parameter int unsigned Cycles = `GPIO_FILTER_CYCLES
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic in_i,
  output logic out_o
);

  localparam int unsigned CtrW = $clog2(Cycles + 1);

  logic            in_q;
  logic            stable_q;
  logic [CtrW-1:0] ctr_q;
  logic            ctr_full;

  assign ctr_full = (ctr_q == CtrW'(Cycles - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_q     <= 1'b0;
      stable_q <= 1'b0;
      ctr_q    <= '0;
    end else begin
      in_q <= in_i;
      // Any change restarts the count
      if (in_i != in_q) begin
        ctr_q <= '0;
      end else if (!ctr_full) begin
        ctr_q <= ctr_q + 1'b1;
      end
      if (ctr_full) begin
        stable_q <= in_q;
      end
    end
  end

  // Bypass still costs one register stage
  assign out_o = enable_i ? stable_q : in_q;

  a_ctr_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctr_q <= CtrW'(Cycles - 1));

endmodule

//--- source/gpio_intr.sv
// Edge and level event detection and sticky interrupt state that the GPIO top level instantiates

`timescale 1ns/1ps

`include "gpio_params.svh"

module gpio_intr
  import gpio_reg_pkg::*;
  import gpio_pin_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  pin_vec_t  data_i,
  input  pin_vec_t  rise_en_i,
  input  pin_vec_t  fall_en_i,
  input  pin_vec_t  hi_en_i,
  input  pin_vec_t  lo_en_i,
  input  pin_vec_t  intr_en_i,
  input  logic      clr_i,
  input  logic      test_i,
  input  reg_word_t wdata_i,
  output pin_vec_t  state_o,
  output pin_vec_t  intr_o
);

  pin_vec_t data_q;
  pin_vec_t ev_rise;
  pin_vec_t ev_fall;
  pin_vec_t ev_high;
  pin_vec_t ev_low;
  pin_vec_t events;
  pin_vec_t clr_mask;
  pin_vec_t test_set;
  pin_vec_t state_q;

  // Previous filtered value for edge detection
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q <= '0;
    end else begin
      data_q <= data_i;
    end
  end

  assign ev_rise = ~data_q &  data_i & rise_en_i;
  assign ev_fall =  data_q & ~data_i & fall_en_i;
  assign ev_high =  data_i & hi_en_i;
  assign ev_low  = ~data_i & lo_en_i;
  assign events  = ev_rise | ev_fall | ev_high | ev_low;

  assign clr_mask = clr_i  ? pin_vec_t'(wdata_i) : '0;
  assign test_set = test_i ? pin_vec_t'(wdata_i) : '0;

  // Hardware events win over write-one-to-clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '0;
    end else begin
      state_q <= (state_q & ~clr_mask) | events | test_set;
    end
  end

  assign state_o = state_q;
  assign intr_o  = state_q & intr_en_i;

  a_clr_test_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(clr_i && test_i));

endmodule

//--- source/gpio_masked_reg.sv
// Pin vector register with direct and per-half masked loads, used for the GPIO outputs and output enables

`timescale 1ns/1ps

`include "gpio_params.svh"

module gpio_masked_reg
  import gpio_reg_pkg::*;
  import gpio_pin_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      wr_i,
  input  logic      lo_wr_i,
  input  logic      hi_wr_i,
  input  reg_word_t wdata_i,
  output pin_vec_t  q_o
);

  pin_vec_t  q;
  half_vec_t mask;
  half_vec_t data;
  half_vec_t upper_q;
  half_vec_t lower_q;

  // Masked write word carries the mask on top
  assign mask = wdata_i[31:16];
  assign data = wdata_i[15:0];

  assign upper_q = q[`GPIO_WIDTH-1:`GPIO_HALF];
  assign lower_q = q[`GPIO_HALF-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      q <= '0;
    end else if (wr_i) begin
      q <= wdata_i;
    end else if (hi_wr_i) begin
      q[`GPIO_WIDTH-1:`GPIO_HALF] <= (mask & data) | (~mask & upper_q);
    end else if (lo_wr_i) begin
      q[`GPIO_HALF-1:0] <= (mask & data) | (~mask & lower_q);
    end
  end

  assign q_o = q;

  // Register block decodes one address per write
  a_one_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({wr_i, lo_wr_i, hi_wr_i}));

endmodule
